// ==== verilog/rot_consts.svh ====
//******************************
// LFSR, sample and word geometry constants
// RNG_PERIOD must lie between 2 and 4 for the 2-bit timer
//******************************

`ifndef ROT_CONSTS_SVH
`define ROT_CONSTS_SVH

// LFSR reset value and Galois feedback mask
`define RNG_SEED 32'hACE12345
`define RNG_TAPS 32'h80200003

// Clock cycles between two samples
`define RNG_PERIOD 4

// Bits per sample
`define RNG_STREAMS 4

// Word geometry
`define SAMPLES_PER_WORD 8
`define WORD_BYTES 4

`endif

// ==== verilog/rot_pkg.sv ====
//******************************
// Shared types of the entropy writer
// AXI channels carry only the fields in use
//******************************

`include "rot_consts.svh"

package rot_pkg;

   typedef logic [31:0]               addr_t;
   typedef logic [31:0]               word_t;
   typedef logic [`RNG_STREAMS-1:0]   sample_t;
   typedef logic [15:0]               count_t;
   typedef logic [1:0]                resp_t;

   // AW channel, single beat
   typedef struct packed {
      addr_t addr;
      logic  valid;
   } aw_chan_t;

   // W channel, last is implied
   typedef struct packed {
      word_t                  data;
      logic [`WORD_BYTES-1:0] strb;
      logic                   valid;
   } w_chan_t;

   // B channel
   typedef struct packed {
      resp_t resp;
      logic  valid;
   } b_chan_t;

   // Write master states
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_SEND,
      ST_RESP,
      ST_DONE
   } wr_state_e;

endpackage

// ==== verilog/rng_timer.sv ====
//******************************
// Sample timer, strobes every RNG_PERIOD enabled cycles
// Count is frozen while disabled
//******************************

`timescale 1ns/1ns
`include "rot_consts.svh"

module rng_timer (
   input  logic clk_i,
   input  logic reset_i,
   input  logic en_i,
   output logic tick_o
);

   localparam logic [1:0] reload_val = 2'(`RNG_PERIOD - 1);

   logic [1:0] cnt_q;
   logic       tick_q;

   // Down-counter with registered strobe at zero
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cnt_q  <= reload_val;
         tick_q <= 1'b0;
      end else begin
         tick_q <= 1'b0;
         if (en_i) begin
            if (cnt_q == '0) begin
               cnt_q  <= reload_val;
               tick_q <= 1'b1;
            end else begin
               cnt_q <= cnt_q - 1'b1;
            end
         end
      end
   end

   assign tick_o = tick_q;

   a_tick_single: assert property (@(posedge clk_i) disable iff (reset_i)
      tick_o |=> !tick_o);

endmodule

// ==== verilog/rng.sv ====
//******************************
// Pseudo random source, 32-bit Galois LFSR
// Not a physical entropy source
//******************************

`timescale 1ns/1ns
`include "rot_consts.svh"

module rng (
   input  logic             clk_i,
   input  logic             reset_i,
   input  logic             en_i,
   output rot_pkg::sample_t sample_o,
   output logic             sample_valid_o
);

   logic             tick;
   logic [31:0]      lfsr_q;
   logic [31:0]      lfsr_next;
   rot_pkg::sample_t sample_q;
   logic             sample_valid_q;

   rng_timer u_timer (
      .clk_i   ( clk_i   ),
      .reset_i ( reset_i ),
      .en_i    ( en_i    ),
      .tick_o  ( tick    )
   );

   // Shift right, fold in taps when the old low bit was set
   assign lfsr_next = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? `RNG_TAPS : 32'h0);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         lfsr_q         <= `RNG_SEED;
         sample_valid_q <= 1'b0;
      end else begin
         sample_valid_q <= tick;
         if (tick) begin
            lfsr_q <= lfsr_next;
         end
      end
   end

   // Sample is taken from the freshly advanced value
   always_ff @(posedge clk_i) begin
      if (tick) begin
         sample_q <= lfsr_next[`RNG_STREAMS-1:0];
      end
   end

   assign sample_o       = sample_q;
   assign sample_valid_o = sample_valid_q;

   // Lockup state must never be reached
   a_lfsr_nonzero: assert property (@(posedge clk_i) disable iff (reset_i)
      lfsr_q != '0);

endmodule

// ==== verilog/entropy_packer.sv ====
//******************************
// Packs SAMPLES_PER_WORD samples into one word
// First sample ends up in the lowest nibble
//******************************

`timescale 1ns/1ns
`include "rot_consts.svh"

module entropy_packer (
   input  logic             clk_i,
   input  logic             reset_i,
   input  rot_pkg::sample_t sample_i,
   input  logic             sample_valid_i,
   output rot_pkg::word_t   word_o,
   output logic             word_valid_o
);

   localparam int unsigned sample_w = $bits(rot_pkg::sample_t);
   localparam int unsigned word_w   = $bits(rot_pkg::word_t);
   localparam int unsigned cnt_w    = $clog2(`SAMPLES_PER_WORD);

   localparam logic [cnt_w-1:0] last_cnt = cnt_w'(`SAMPLES_PER_WORD - 1);

   rot_pkg::word_t   word_q;
   logic [cnt_w-1:0] cnt_q;
   logic             word_valid_q;

   // New samples enter at the top and move down
   always_ff @(posedge clk_i) begin
      if (sample_valid_i) begin
         word_q <= {sample_i, word_q[word_w-1:sample_w]};
      end
   end

   // Sample counter, kept across runs
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         cnt_q        <= '0;
         word_valid_q <= 1'b0;
      end else begin
         word_valid_q <= 1'b0;
         if (sample_valid_i) begin
            if (cnt_q == last_cnt) begin
               cnt_q        <= '0;
               word_valid_q <= 1'b1;
            end else begin
               cnt_q <= cnt_q + 1'b1;
            end
         end
      end
   end

   assign word_o       = word_q;
   assign word_valid_o = word_valid_q;

endmodule

// ==== verilog/axi_write_fsm.sv ====
//******************************
// Single-beat AXI write master, one write per word
// Full strobes only, no IDs and no bursts
//******************************

`timescale 1ns/1ns
`include "rot_consts.svh"

module axi_write_fsm (
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              start_i,
   input  rot_pkg::addr_t    base_addr_i,
   input  rot_pkg::count_t   num_words_i,
   input  rot_pkg::word_t    word_i,
   input  logic              word_valid_i,
   input  rot_pkg::b_chan_t  b_i,
   input  logic              aw_ready_i,
   input  logic              w_ready_i,
   output logic              rng_en_o,
   output rot_pkg::aw_chan_t aw_o,
   output rot_pkg::w_chan_t  w_o,
   output logic              b_ready_o,
   output logic              done_o,
   output logic              err_o
);

   rot_pkg::wr_state_e state_q;
   rot_pkg::addr_t     base_q;
   rot_pkg::count_t    num_q;
   rot_pkg::count_t    idx_q;
   rot_pkg::count_t    idx_next;
   rot_pkg::word_t     word_q;
   rot_pkg::addr_t     addr;
   logic               active_q;
   logic               aw_valid_q;
   logic               w_valid_q;
   logic               err_q;
   logic               aw_done;
   logic               w_done;
   logic               take_start;

   assign take_start = start_i && !active_q;
   assign idx_next   = idx_q + 1'b1;
   assign addr       = base_q + rot_pkg::addr_t'(idx_q) * `WORD_BYTES;

   // Channel finished either earlier or in this cycle
   assign aw_done = !aw_valid_q || aw_ready_i;
   assign w_done  = !w_valid_q || w_ready_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q    <= rot_pkg::ST_IDLE;
         active_q   <= 1'b0;
         idx_q      <= '0;
         aw_valid_q <= 1'b0;
         w_valid_q  <= 1'b0;
         err_q      <= 1'b0;
      end else begin
         case (state_q)
            rot_pkg::ST_IDLE: begin
               if (active_q && word_valid_i) begin
                  state_q    <= rot_pkg::ST_SEND;
                  aw_valid_q <= 1'b1;
                  w_valid_q  <= 1'b1;
               end
            end
            rot_pkg::ST_SEND: begin
               if (aw_ready_i) begin
                  aw_valid_q <= 1'b0;
               end
               if (w_ready_i) begin
                  w_valid_q <= 1'b0;
               end
               if (aw_done && w_done) begin
                  state_q <= rot_pkg::ST_RESP;
               end
            end
            rot_pkg::ST_RESP: begin
               if (b_i.valid) begin
                  // Error flag stays set until the next start
                  if (b_i.resp != '0) begin
                     err_q <= 1'b1;
                  end
                  idx_q <= idx_next;
                  if (idx_next == num_q) begin
                     state_q  <= rot_pkg::ST_DONE;
                     active_q <= 1'b0;
                  end else begin
                     state_q <= rot_pkg::ST_IDLE;
                  end
               end
            end
            default: begin
               state_q <= rot_pkg::ST_IDLE;
            end
         endcase

         // A zero word count finishes at once
         if (take_start) begin
            idx_q <= '0;
            err_q <= 1'b0;
            if (num_words_i == '0) begin
               state_q <= rot_pkg::ST_DONE;
            end else begin
               active_q <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (take_start) begin
         base_q <= base_addr_i;
         num_q  <= num_words_i;
      end
      if (state_q == rot_pkg::ST_IDLE && word_valid_i) begin
         word_q <= word_i;
      end
   end

   assign rng_en_o   = (state_q == rot_pkg::ST_IDLE) && active_q;
   assign aw_o.addr  = addr;
   assign aw_o.valid = aw_valid_q;
   assign w_o.data   = word_q;
   assign w_o.strb   = '1;
   assign w_o.valid  = w_valid_q;
   assign b_ready_o  = (state_q == rot_pkg::ST_RESP);
   assign done_o     = (state_q == rot_pkg::ST_DONE);
   assign err_o      = err_q;

   a_aw_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      aw_o.valid && !aw_ready_i |=> aw_o.valid && $stable(aw_o.addr));

   a_w_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      w_o.valid && !w_ready_i |=> w_o.valid && $stable(w_o.data));

   // Gated source must keep words away while a write is in flight
   a_word_in_idle: assert property (@(posedge clk_i) disable iff (reset_i)
      word_valid_i |-> state_q == rot_pkg::ST_IDLE);

endmodule

// ==== verilog/entropy_axi_wrap.sv ====
//******************************
// Entropy to memory top level
// AXI write channels only, flattened to ports
//******************************

`timescale 1ns/1ns
`include "rot_consts.svh"

module entropy_axi_wrap (
   input  logic                   clk_i,
   input  logic                   reset_i,

   // Run control
   input  logic                   start_i,
   input  rot_pkg::addr_t         base_addr_i,
   input  rot_pkg::count_t        num_words_i,
   output logic                   done_o,
   output logic                   err_o,

   // AXI AW channel
   output rot_pkg::addr_t         aw_addr_o,
   output logic                   aw_valid_o,
   input  logic                   aw_ready_i,

   // AXI W channel
   output rot_pkg::word_t         w_data_o,
   output logic [`WORD_BYTES-1:0] w_strb_o,
   output logic                   w_valid_o,
   input  logic                   w_ready_i,

   // AXI B channel
   input  rot_pkg::resp_t         b_resp_i,
   input  logic                   b_valid_i,
   output logic                   b_ready_o
);

   rot_pkg::sample_t  sample;
   logic              sample_valid;
   rot_pkg::word_t    word;
   logic              word_valid;
   logic              rng_en;
   rot_pkg::aw_chan_t aw_chan;
   rot_pkg::w_chan_t  w_chan;
   rot_pkg::b_chan_t  b_chan;

   // Unpack the request channels
   assign aw_addr_o  = aw_chan.addr;
   assign aw_valid_o = aw_chan.valid;
   assign w_data_o   = w_chan.data;
   assign w_strb_o   = w_chan.strb;
   assign w_valid_o  = w_chan.valid;

   // Pack the response channel
   assign b_chan.resp  = b_resp_i;
   assign b_chan.valid = b_valid_i;

   rng u_rng (
      .clk_i          ( clk_i        ),
      .reset_i        ( reset_i      ),
      .en_i           ( rng_en       ),
      .sample_o       ( sample       ),
      .sample_valid_o ( sample_valid )
   );

   entropy_packer u_packer (
      .clk_i          ( clk_i        ),
      .reset_i        ( reset_i      ),
      .sample_i       ( sample       ),
      .sample_valid_i ( sample_valid ),
      .word_o         ( word         ),
      .word_valid_o   ( word_valid   )
   );

   axi_write_fsm u_writer (
      .clk_i        ( clk_i       ),
      .reset_i      ( reset_i     ),
      .start_i      ( start_i     ),
      .base_addr_i  ( base_addr_i ),
      .num_words_i  ( num_words_i ),
      .word_i       ( word        ),
      .word_valid_i ( word_valid  ),
      .b_i          ( b_chan      ),
      .aw_ready_i   ( aw_ready_i  ),
      .w_ready_i    ( w_ready_i   ),
      .rng_en_o     ( rng_en      ),
      .aw_o         ( aw_chan     ),
      .w_o          ( w_chan      ),
      .b_ready_o    ( b_ready_o   ),
      .done_o       ( done_o      ),
      .err_o        ( err_o       )
   );

endmodule

// ==== test/tb_entropy_axi.sv ====
//******************************
// Testbench for entropy_axi_wrap with four runs back to back
// Slave answers SLVERR only at err_addr
// Ready and response delays of 0 to 3 cycles
//******************************

`timescale 1ns/1ns
`include "rot_consts.svh"

module tb_entropy_axi;

   localparam int total_words = 11;
   localparam int watchdog_cycles =
      total_words * (`SAMPLES_PER_WORD * `RNG_PERIOD + 12) + 200;
   localparam rot_pkg::addr_t err_addr = 32'h3000_0008;

   logic                   clk_i = 1'b0;
   logic                   reset_i;
   logic                   start_i;
   rot_pkg::addr_t         base_addr_i;
   rot_pkg::count_t        num_words_i;
   logic                   done_o;
   logic                   err_o;
   rot_pkg::addr_t         aw_addr_o;
   logic                   aw_valid_o;
   logic                   aw_ready_i = 1'b0;
   rot_pkg::word_t         w_data_o;
   logic [`WORD_BYTES-1:0] w_strb_o;
   logic                   w_valid_o;
   logic                   w_ready_i = 1'b0;
   rot_pkg::resp_t         b_resp_i = '0;
   logic                   b_valid_i = 1'b0;
   logic                   b_ready_o;

   // Run context from the main sequence
   string          test_name = "reset";
   rot_pkg::addr_t exp_base = '0;
   int             exp_num = 0;
   logic           started = 1'b0;
   int             ctrl_errs = 0;
   logic [1:0]     aw_dly [16];
   logic [1:0]     w_dly [16];
   logic [1:0]     b_dly [16];

   // Slave model state
   logic [31:0]    lfsr_ref = `RNG_SEED;
   rot_pkg::word_t exp_word;
   rot_pkg::addr_t exp_addr;
   rot_pkg::resp_t resp_cur = '0;
   logic [3:0]     wr_idx = '0;
   int             aw_wait = 0;
   int             w_wait = 0;
   int             b_wait = 0;
   int             aw_run = 0;
   int             w_run = 0;
   int             b_run = 0;
   logic           aw_got = 1'b0;
   logic           w_got = 1'b0;
   logic           b_pend = 1'b0;
   logic           b_hs = 1'b0;
   logic           saw_err = 1'b0;
   int             chk_errs = 0;
   int             sva_errs = 0;

   entropy_axi_wrap i_dut (
      .clk_i       ( clk_i       ),
      .reset_i     ( reset_i     ),
      .start_i     ( start_i     ),
      .base_addr_i ( base_addr_i ),
      .num_words_i ( num_words_i ),
      .done_o      ( done_o      ),
      .err_o       ( err_o       ),
      .aw_addr_o   ( aw_addr_o   ),
      .aw_valid_o  ( aw_valid_o  ),
      .aw_ready_i  ( aw_ready_i  ),
      .w_data_o    ( w_data_o    ),
      .w_strb_o    ( w_strb_o    ),
      .w_valid_o   ( w_valid_o   ),
      .w_ready_i   ( w_ready_i   ),
      .b_resp_i    ( b_resp_i    ),
      .b_valid_i   ( b_valid_i   ),
      .b_ready_o   ( b_ready_o   )
   );

   initial begin
      forever #50 clk_i = ~clk_i;
   end

   // Reference word from eight LFSR steps with the first sample in the low nibble
   task automatic build_ref_word(output rot_pkg::word_t w);
      logic [31:0] shifted;
      w = '0;
      for (int i = 0; i < `SAMPLES_PER_WORD; i++) begin
         shifted = lfsr_ref >> 1;
         if (lfsr_ref[0]) begin
            shifted = shifted ^ `RNG_TAPS;
         end
         lfsr_ref = shifted;
         w[i*`RNG_STREAMS +: `RNG_STREAMS] = shifted[`RNG_STREAMS-1:0];
      end
   endtask

   // AXI slave model acting on the falling edge
   always @(negedge clk_i) begin
      if (!reset_i) begin
         if (b_hs) begin
            // Sticky error flag reflects every response of the run so far
            assert (err_o == saw_err) else begin
               chk_errs = chk_errs + 1;
               $display("error %s err_o after response expected %b actual %b",
                        test_name, saw_err, err_o);
            end
            b_valid_i = 1'b0;
            b_hs      = 1'b0;
         end
         if (b_pend && !b_valid_i) begin
            if (b_wait == 0) begin
               b_valid_i = 1'b1;
               b_resp_i  = resp_cur;
            end else begin
               b_wait = b_wait - 1;
            end
         end
         if (b_valid_i && b_ready_o) begin
            b_hs    = 1'b1;
            b_pend  = 1'b0;
            b_run   = b_run + 1;
            wr_idx  = wr_idx + 1'b1;
            saw_err = saw_err | (b_resp_i != 2'b00);
         end

         aw_ready_i = 1'b0;
         if (aw_valid_o) begin
            if (aw_wait == 0) begin
               aw_ready_i = 1'b1;
               exp_addr   = exp_base + rot_pkg::addr_t'(aw_run) * 4;
               assert (aw_addr_o == exp_addr) else begin
                  chk_errs = chk_errs + 1;
                  $display("error %s aw_addr expected %h actual %h",
                           test_name, exp_addr, aw_addr_o);
               end
               resp_cur = (aw_addr_o == err_addr) ? 2'b10 : 2'b00;
               aw_run   = aw_run + 1;
               aw_got   = 1'b1;
            end else begin
               aw_wait = aw_wait - 1;
            end
         end else begin
            aw_wait = int'(aw_dly[wr_idx]);
         end

         w_ready_i = 1'b0;
         if (w_valid_o) begin
            if (w_wait == 0) begin
               w_ready_i = 1'b1;
               build_ref_word(exp_word);
               assert (w_data_o == exp_word) else begin
                  chk_errs = chk_errs + 1;
                  $display("error %s w_data expected %h actual %h",
                           test_name, exp_word, w_data_o);
               end
               w_run = w_run + 1;
               w_got = 1'b1;
            end else begin
               w_wait = w_wait - 1;
            end
         end else begin
            w_wait = int'(w_dly[wr_idx]);
         end

         // Response only once both halves of the write are in
         if (aw_got && w_got) begin
            aw_got = 1'b0;
            w_got  = 1'b0;
            b_pend = 1'b1;
            b_wait = int'(b_dly[wr_idx]);
         end

         if (done_o) begin
            assert (aw_run == exp_num && w_run == exp_num && b_run == exp_num) else begin
               chk_errs = chk_errs + 1;
               $display("error %s writes before done expected %0d actual %0d/%0d/%0d",
                        test_name, exp_num, aw_run, w_run, b_run);
            end
            assert (err_o == saw_err) else begin
               chk_errs = chk_errs + 1;
               $display("error %s err_o expected %b actual %b", test_name, saw_err, err_o);
            end
            aw_run  = 0;
            w_run   = 0;
            b_run   = 0;
            saw_err = 1'b0;
         end
      end
   end

   a_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
      !started |-> !aw_valid_o && !w_valid_o && !b_ready_o && !done_o)
      else begin
         sva_errs = sva_errs + 1;
         $display("Bus activity seen before the first start");
      end

   a_aw_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o))
      else begin
         sva_errs = sva_errs + 1;
         $display("AW address or valid changed while waiting for ready");
      end

   a_w_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o))
      else begin
         sva_errs = sva_errs + 1;
         $display("W data or valid changed while waiting for ready");
      end

   a_strb_full: assert property (@(posedge clk_i) disable iff (reset_i)
      w_valid_o |-> w_strb_o == '1)
      else begin
         sva_errs = sva_errs + 1;
         $display("error %s w_strb expected f actual %h", test_name, w_strb_o);
      end

   a_done_single: assert property (@(posedge clk_i) disable iff (reset_i)
      done_o |=> !done_o)
      else begin
         sva_errs = sva_errs + 1;
         $display("Done strobe lasted more than one cycle");
      end

   // One run from start strobe to done strobe
   task automatic run_words(input string name, input rot_pkg::addr_t base, input int num);
      test_name = name;
      exp_base  = base;
      exp_num   = num;
      @(negedge clk_i);
      started     = 1'b1;
      start_i     = 1'b1;
      base_addr_i = base;
      num_words_i = rot_pkg::count_t'(num);
      @(negedge clk_i);
      start_i = 1'b0;
      assert (err_o == 1'b0) else begin
         ctrl_errs = ctrl_errs + 1;
         $display("error %s err_o after start expected 0 actual %b", name, err_o);
      end
      while (done_o !== 1'b1) begin
         @(negedge clk_i);
      end
      @(negedge clk_i);
   endtask

   initial begin
      void'($urandom(32'hea60));
      for (int i = 0; i < 16; i++) begin
         aw_dly[i] = 2'($urandom % 4);
         w_dly[i]  = 2'($urandom % 4);
         b_dly[i]  = 2'($urandom % 4);
      end
      reset_i     = 1'b1;
      start_i     = 1'b0;
      base_addr_i = '0;
      num_words_i = '0;
      repeat (5) @(negedge clk_i);
      reset_i = 1'b0;
      repeat (10) @(negedge clk_i);

      run_words("run_a", 32'h1000_0000, 3);
      run_words("run_b", 32'h2000_0040, 3);
      run_words("run_err", 32'h3000_0000, 4);
      assert (err_o == 1'b1) else begin
         ctrl_errs = ctrl_errs + 1;
         $display("error run_err err_o after run expected 1 actual %b", err_o);
      end
      run_words("run_clear", 32'h4000_0000, 1);
      repeat (5) @(negedge clk_i);

      $display("Error counts: data %0d, control %0d, protocol %0d",
               chk_errs, ctrl_errs, sva_errs);
      if (chk_errs + ctrl_errs + sva_errs == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

   // Watchdog sized from the total number of words
   initial begin
      repeat (watchdog_cycles) @(posedge clk_i);
      $display("Watchdog expired after %0d cycles with a run still open", watchdog_cycles);
      $display("Verification failed");
      $finish;
   end

endmodule

// ==== flist.f ====
+incdir+verilog
verilog/rot_pkg.sv
verilog/rng_timer.sv
verilog/rng.sv
verilog/entropy_packer.sv
verilog/axi_write_fsm.sv
verilog/entropy_axi_wrap.sv
test/tb_entropy_axi.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the entropy writer testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
   -f flist.f \
   --top-module tb_entropy_axi

sim_status=0
./obj_dir/Vtb_entropy_axi > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Verification failed" sim.log || [ "$sim_status" -ne 0 ]; then
   echo "Simulation FAILED"
   exit 1
fi

echo "Simulation finished without failures"
exit 0
